// File: design/masked_arith_macros.svh
//=================================================
// masked arithmetic constants
// share width, ML-DSA modulus, pipeline depths
//=================================================
`ifndef MASKED_ARITH_MACROS_SVH
`define MASKED_ARITH_MACROS_SVH

// share width, arithmetic shares live mod 2^24
`define MASK_WIDTH      24
`define MLDSA_Q         24'd8380417
// 2^23 - Q, puts the ">= Q" decision on bit 23
`define ROLLER          24'd8191
// one carry stage per bit below bit 23
`define A2B_STAGES      23
`define B2A_CYCLES      2
`define ALIGN_DEPTH     (`A2B_STAGES + `B2A_CYCLES)
`define ADDSUB_LATENCY  28

`endif

// File: design/masked_arith_pkg.sv
//=================================================
// masked arithmetic types
// share words, share pairs, Boolean bit shares
//=================================================
`include "masked_arith_macros.svh"

package masked_arith_pkg;

    // one arithmetic share mod 2^24
    typedef logic [`MASK_WIDTH-1:0] share_word_t;

    // first-order sharing, value = s0 + s1 mod 2^24
    typedef struct packed {
        share_word_t s1;
        share_word_t s0;
    } share_pair_t;

    // Boolean sharing of one bit, value = b0 ^ b1
    typedef struct packed {
        logic b1;
        logic b0;
    } bool_bit_t;

endpackage

// File: design/masked_share_if.sv
//=================================================
// masked operand link
// prepared u and v share pairs with their strobe
//=================================================
`timescale 1ns/1ps

interface masked_share_if;
    import masked_arith_pkg::*;

    // operation strobe
    logic        valid;
    // first operand shares
    share_pair_t u;
    // second operand, already negated for sub
    share_pair_t v;

    // operand_prep side
    modport src (output valid, output u, output v);
    // adder side
    modport dst (input valid, input u, input v);

endinterface

// File: design/operand_prep.sv
//=================================================
// operand preparation
// registers input shares, negates v on subtract
//=================================================
`timescale 1ns/1ps
`include "masked_arith_macros.svh"

module operand_prep (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          zeroize,
    input  logic                          valid_in,
    input  logic                          sub,
    input  masked_arith_pkg::share_pair_t u_in,
    input  masked_arith_pkg::share_pair_t v_in,
    masked_share_if.src                   ops
);
    import masked_arith_pkg::*;

    share_pair_t v_neg;

    // Q - v0 and -v1 recombine to Q - v, keeps the sum in [0, 2Q)
    always_comb begin
        if (sub) begin
            v_neg.s0 = `MLDSA_Q - v_in.s0;
            v_neg.s1 = ~v_in.s1 + 24'd1;
        end else begin
            v_neg = v_in;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ops.valid <= 1'b0;
            ops.u     <= '0;
            ops.v     <= '0;
        end else if (zeroize) begin
            ops.valid <= 1'b0;
            ops.u     <= '0;
            ops.v     <= '0;
        end else begin
            ops.valid <= valid_in;
            ops.u     <= u_in;
            ops.v     <= v_neg;
        end
    end

    // an unknown sub would pick the wrong v shares for a live operation
    a_sub_known: assert property (@(posedge clk) disable iff (!reset_n)
        valid_in |-> !$isunknown(sub));

endmodule

// File: design/masked_share_adder.sv
//=================================================
// masked share adder
// share-wise sum, raw and roller-offset copies
//=================================================
`timescale 1ns/1ps
`include "masked_arith_macros.svh"

module masked_share_adder (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic                           zeroize,
    masked_share_if.dst                    ops,
    output masked_arith_pkg::share_pair_t  sum_raw,
    output masked_arith_pkg::share_pair_t  sum_rolled,
    output logic                           sum_valid
);
    import masked_arith_pkg::*;

    share_pair_t add_d;
    share_pair_t roll_d;

    // shares stay apart, each adds only to its own counterpart
    always_comb begin
        add_d.s0  = ops.u.s0 + ops.v.s0;
        add_d.s1  = ops.u.s1 + ops.v.s1;
        // offset lands on share 0 only
        roll_d.s0 = ops.u.s0 + ops.v.s0 + `ROLLER;
        roll_d.s1 = ops.u.s1 + ops.v.s1;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            sum_raw    <= '0;
            sum_rolled <= '0;
            sum_valid  <= 1'b0;
        end else if (zeroize) begin
            sum_raw    <= '0;
            sum_rolled <= '0;
            sum_valid  <= 1'b0;
        end else begin
            sum_raw    <= add_d;
            sum_rolled <= roll_d;
            sum_valid  <= ops.valid;
        end
    end

endmodule

// File: design/a2b_msb_extract.sv
//=================================================
// masked MSB extraction
// pipelined carry chain, Boolean shares of bit 23
//=================================================
`timescale 1ns/1ps
`include "masked_arith_macros.svh"

module a2b_msb_extract (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          zeroize,
    input  masked_arith_pkg::share_pair_t x,
    input  logic [`MASK_WIDTH-1:0]        rnd,
    output masked_arith_pkg::bool_bit_t   msb
);
    import masked_arith_pkg::*;

    localparam int LAST    = `A2B_STAGES - 1;
    localparam int TOP_BIT = `MASK_WIDTH - 1;

    // per-stage copies of the share words and the shared carry
    share_word_t a_q [`A2B_STAGES];
    share_word_t b_q [`A2B_STAGES];
    bool_bit_t   c_q [`A2B_STAGES];

    // carry out = maj(a, b, c) = ((a ^ c) & (b ^ c)) ^ c
    // a sits in share 0 only, b in share 1 only
    function automatic bool_bit_t carry_step(logic a_bit, logic b_bit,
                                             bool_bit_t c, logic r);
        logic      p0;
        logic      p1;
        logic      q0;
        logic      q1;
        bool_bit_t z;
        p0 = a_bit ^ c.b0;
        p1 = c.b1;
        q0 = c.b0;
        q1 = b_bit ^ c.b1;
        // ISW AND, cross terms folded into the fresh bit first
        z.b0 = (p0 & q0) ^ r;
        z.b1 = (p1 & q1) ^ ((r ^ (p0 & q1)) ^ (p1 & q0));
        carry_step.b0 = z.b0 ^ c.b0;
        carry_step.b1 = z.b1 ^ c.b1;
    endfunction

    genvar k;
    generate
        for (k = 0; k < `A2B_STAGES; k++) begin : g_stage
            share_word_t a_d;
            share_word_t b_d;
            bool_bit_t   c_d;

            if (k == 0) begin : g_first
                // no carry into bit 0
                assign a_d = x.s0;
                assign b_d = x.s1;
                assign c_d = '0;
            end else begin : g_next
                assign a_d = a_q[k-1];
                assign b_d = b_q[k-1];
                assign c_d = c_q[k-1];
            end

            // stage k resolves the carry into bit k+1
            always_ff @(posedge clk or negedge reset_n) begin
                if (!reset_n) begin
                    a_q[k] <= '0;
                    b_q[k] <= '0;
                    c_q[k] <= '0;
                end else if (zeroize) begin
                    a_q[k] <= '0;
                    b_q[k] <= '0;
                    c_q[k] <= '0;
                end else begin
                    a_q[k] <= a_d;
                    b_q[k] <= b_d;
                    c_q[k] <= carry_step(a_d[k], b_d[k], c_d, rnd[k]);
                end
            end
        end
    endgenerate

    // bit 23 = a23 ^ b23 ^ c23, spare random bit refreshes both shares
    assign msb.b0 = a_q[LAST][TOP_BIT] ^ c_q[LAST].b0 ^ rnd[TOP_BIT];
    assign msb.b1 = b_q[LAST][TOP_BIT] ^ c_q[LAST].b1 ^ rnd[TOP_BIT];

endmodule

// File: design/b2a_bit_conv.sv
//=================================================
// masked B2A for one bit
// Goubin conversion over two registered cycles
//=================================================
`timescale 1ns/1ps

module b2a_bit_conv (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          zeroize,
    input  masked_arith_pkg::bool_bit_t   b,
    input  masked_arith_pkg::share_word_t rnd,
    output masked_arith_pkg::share_pair_t a
);
    import masked_arith_pkg::*;

    share_word_t xp;
    share_word_t r_w;
    // first half results
    share_word_t t_q;
    share_word_t g_q;
    logic        xp_q;
    logic        r_q;

    // bit shares widened to words
    assign xp  = share_word_t'(b.b0);
    assign r_w = share_word_t'(b.b1);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            t_q  <= '0;
            g_q  <= '0;
            xp_q <= 1'b0;
            r_q  <= 1'b0;
            a    <= '0;
        end else if (zeroize) begin
            t_q  <= '0;
            g_q  <= '0;
            xp_q <= 1'b0;
            r_q  <= 1'b0;
            a    <= '0;
        end else begin
            // cycle 1: ((x' ^ g) - g) ^ x', g moves on to g ^ r
            t_q  <= ((xp ^ rnd) - rnd) ^ xp;
            g_q  <= rnd ^ r_w;
            xp_q <= b.b0;
            r_q  <= b.b1;
            // cycle 2: A = ((x' ^ g') - g') ^ t, so A + r = x
            a.s0 <= ((share_word_t'(xp_q) ^ g_q) - g_q) ^ t_q;
            a.s1 <= share_word_t'(r_q);
        end
    end

endmodule

// File: design/share_delay.sv
//=================================================
// share delay line
// clearable shift register for any payload type
//=================================================
`timescale 1ns/1ps

module share_delay #(
    parameter type T     = logic,
    parameter int  DEPTH = 1
) (
    input  logic clk,
    input  logic reset_n,
    input  logic zeroize,
    input  T     d,
    output T     q
);

    T pipe [DEPTH];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                pipe[i] <= '0;
            end
        end else if (zeroize) begin
            for (int i = 0; i < DEPTH; i++) begin
                pipe[i] <= '0;
            end
        end else begin
            pipe[0] <= d;
            for (int i = 1; i < DEPTH; i++) begin
                pipe[i] <= pipe[i-1];
            end
        end
    end

    // oldest entry
    assign q = pipe[DEPTH-1];

    // a zero-depth line would leave q with no stage
    a_depth: assert property (@(posedge clk) disable iff (!reset_n) DEPTH >= 1);

endmodule

// File: design/modq_reduce_out.sv
//=================================================
// mod-Q reduction and output register
// subtracts Q times the shared bit from the sum
//=================================================
`timescale 1ns/1ps
`include "masked_arith_macros.svh"

module modq_reduce_out (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          zeroize,
    input  masked_arith_pkg::share_pair_t sum,
    input  logic                          sum_valid,
    input  masked_arith_pkg::share_pair_t bit_arith,
    output masked_arith_pkg::share_pair_t res,
    output logic                          valid_out
);
    import masked_arith_pkg::*;

    // -Q mod 2^24
    localparam share_word_t NEG_Q = ~`MLDSA_Q + 24'd1;

    share_pair_t red;

    // each share scaled by -Q, products recombine to -Q * bit
    always_comb begin
        red.s0 = sum.s0 + bit_arith.s0 * NEG_Q;
        red.s1 = sum.s1 + bit_arith.s1 * NEG_Q;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            res       <= '0;
            valid_out <= 1'b0;
        end else if (zeroize) begin
            res       <= '0;
            valid_out <= 1'b0;
        end else begin
            // shares read zero whenever no result is presented
            res       <= sum_valid ? red : '0;
            valid_out <= sum_valid;
        end
    end

    // a clear empties the incoming strobe line as well as the output flop
    a_zeroize_quiet: assert property (@(posedge clk) disable iff (!reset_n)
        zeroize |=> (!valid_out && !sum_valid));

endmodule

// File: design/masked_addsub_top.sv
//=================================================
// masked modular add/sub, ML-DSA butterfly
// shared (u +/- v) mod Q without unmasking
//=================================================
`timescale 1ns/1ps
`include "masked_arith_macros.svh"

module masked_addsub_top (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   zeroize,
    input  logic                   valid_in,
    input  logic                   sub,
    input  logic [`MASK_WIDTH-1:0] u0,
    input  logic [`MASK_WIDTH-1:0] u1,
    input  logic [`MASK_WIDTH-1:0] v0,
    input  logic [`MASK_WIDTH-1:0] v1,
    input  logic [`MASK_WIDTH-1:0] rnd_a2b,
    input  logic [`MASK_WIDTH-1:0] rnd_b2a,
    output logic [`MASK_WIDTH-1:0] res0,
    output logic [`MASK_WIDTH-1:0] res1,
    output logic                   valid_out
);
    import masked_arith_pkg::*;

    share_pair_t u_in;
    share_pair_t v_in;
    share_pair_t sum_raw;
    share_pair_t sum_rolled;
    share_pair_t sum_dly;
    share_pair_t bit_arith;
    share_pair_t res;
    bool_bit_t   msb;
    logic        sum_valid;
    logic        valid_dly;

    masked_share_if ops_if ();

    assign u_in.s0 = u0;
    assign u_in.s1 = u1;
    assign v_in.s0 = v0;
    assign v_in.s1 = v1;

    //================================================
    // input side
    //================================================
    operand_prep u_prep (
        .clk(clk), .reset_n(reset_n), .zeroize(zeroize),
        .valid_in(valid_in), .sub(sub),
        .u_in(u_in), .v_in(v_in),
        .ops(ops_if.src)
    );

    //================================================
    // processing
    //================================================
    masked_share_adder u_adder (
        .clk(clk), .reset_n(reset_n), .zeroize(zeroize),
        .ops(ops_if.dst),
        .sum_raw(sum_raw), .sum_rolled(sum_rolled),
        .sum_valid(sum_valid)
    );

    // 23 cycles, one random bit per carry stage
    a2b_msb_extract u_a2b (
        .clk(clk), .reset_n(reset_n), .zeroize(zeroize),
        .x(sum_rolled), .rnd(rnd_a2b), .msb(msb)
    );

    b2a_bit_conv u_b2a (
        .clk(clk), .reset_n(reset_n), .zeroize(zeroize),
        .b(msb), .rnd(rnd_b2a), .a(bit_arith)
    );

    // raw sum and strobe wait out the A2B + B2A path
    share_delay #(.T(share_pair_t), .DEPTH(`ALIGN_DEPTH)) u_sum_dly (
        .clk(clk), .reset_n(reset_n), .zeroize(zeroize),
        .d(sum_raw), .q(sum_dly)
    );

    share_delay #(.T(logic), .DEPTH(`ALIGN_DEPTH)) u_valid_dly (
        .clk(clk), .reset_n(reset_n), .zeroize(zeroize),
        .d(sum_valid), .q(valid_dly)
    );

    //================================================
    // output side
    //================================================
    modq_reduce_out u_reduce (
        .clk(clk), .reset_n(reset_n), .zeroize(zeroize),
        .sum(sum_dly), .sum_valid(valid_dly), .bit_arith(bit_arith),
        .res(res), .valid_out(valid_out)
    );

    assign res0 = res.s0;
    assign res1 = res.s1;

endmodule

// File: sim/tb_masked_addsub.sv
//=================================================
// testbench for the masked modular add/sub
// random share splits, reference model, scoreboard
//=================================================
`timescale 1ns/1ps

module tb_masked_addsub;

    localparam logic [23:0] Q          = 24'd8380417;
    localparam int          LATENCY    = 28;
    localparam int          DRAIN_MAX  = 100;
    localparam integer      SEED       = 32'h7c02_db1e;

    logic        clk;
    logic        reset_n;
    logic        zeroize;
    logic        valid_in;
    logic        sub;
    logic [23:0] u0;
    logic [23:0] u1;
    logic [23:0] v0;
    logic [23:0] v1;
    logic [23:0] rnd_a2b;
    logic [23:0] rnd_b2a;
    logic [23:0] res0;
    logic [23:0] res1;
    logic        valid_out;

    integer stim_seed = SEED;
    // separate stream for the mask ports
    integer mask_seed = ~SEED;

    // scoreboard, one entry per issued operation
    logic [23:0] exp_q [$];
    string       name_q [$];
    int          issue_q [$];

    int          cycle_cnt = 0;
    int          mismatch_cnt = 0;
    int          latency_err_cnt = 0;
    int          other_err_cnt = 0;
    bit          aborted = 1'b0;
    logic [23:0] got_val;
    logic [23:0] exp_val;
    string       exp_name;
    int          issued_at;

    masked_addsub_top UUT (
        .clk(clk), .reset_n(reset_n), .zeroize(zeroize),
        .valid_in(valid_in), .sub(sub),
        .u0(u0), .u1(u1), .v0(v0), .v1(v1),
        .rnd_a2b(rnd_a2b), .rnd_b2a(rnd_b2a),
        .res0(res0), .res1(res1), .valid_out(valid_out)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    function automatic logic [23:0] rand_word();
        logic [31:0] r;
        r = $random(stim_seed);
        return r[23:0];
    endfunction

    function automatic logic [23:0] rand_below_q();
        logic [31:0] r;
        r = $random(stim_seed);
        r = r % {8'd0, Q};
        return r[23:0];
    endfunction

    function automatic logic [23:0] next_mask_word();
        logic [31:0] r;
        r = $random(mask_seed);
        return r[23:0];
    endfunction

    // (u + v) mod Q, or (u - v + Q) mod Q, with u and v below Q
    function automatic logic [23:0] expected_addsub(input logic [23:0] u,
                                                    input logic [23:0] v,
                                                    input logic s);
        logic [24:0] t;
        if (s) begin
            t = {1'b0, u} + {1'b0, Q} - {1'b0, v};
        end else begin
            t = {1'b0, u} + {1'b0, v};
        end
        // t stays below 2Q, one correction is enough
        if (t >= {1'b0, Q}) begin
            t = t - {1'b0, Q};
        end
        return t[23:0];
    endfunction

    // fresh masks on every cycle
    always @(posedge clk) begin
        rnd_a2b <= next_mask_word();
        rnd_b2a <= next_mask_word();
    end

    // share 1 = x - share 0, mod 2^24
    task automatic issue_op(input logic [23:0] u, input logic [23:0] v,
                            input logic s, input string name);
        logic [23:0] us0;
        logic [23:0] vs0;
        us0 = rand_word();
        vs0 = rand_word();
        @(posedge clk);
        valid_in <= 1'b1;
        sub      <= s;
        u0       <= us0;
        u1       <= u - us0;
        v0       <= vs0;
        v1       <= v - vs0;
        exp_q.push_back(expected_addsub(u, v, s));
        name_q.push_back(name);
        // counter still holds the pre-edge value here
        issue_q.push_back(cycle_cnt + 1);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            valid_in <= 1'b0;
        end
    endtask

    task automatic wait_drain(input string what);
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_MAX) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            other_err_cnt++;
            aborted = 1'b1;
            $display("ERROR: timed out waiting for %s results, %0d never arrived",
                     what, exp_q.size());
        end
    endtask

    //=================================================
    // test phases
    //=================================================
    task automatic run_phase(input int phase);
        int          i;
        logic [23:0] x;
        logic [23:0] r;
        case (phase)
            0: begin
                for (i = 0; i < 200; i++) begin
                    issue_op(rand_below_q(), rand_below_q(), 1'b0, "add");
                end
                idle_cycles(1);
                wait_drain("add");
            end
            1: begin
                for (i = 0; i < 200; i++) begin
                    issue_op(rand_below_q(), rand_below_q(), 1'b1, "sub");
                end
                idle_cycles(1);
                wait_drain("sub");
            end
            2: begin
                for (i = 0; i < 4; i++) begin
                    x = rand_below_q();
                    if (x == 24'd0) begin
                        x = 24'd1;
                    end
                    issue_op(x, Q - x, 1'b0, "u+v=Q");
                    issue_op(Q - 24'd1, Q - 24'd1, 1'b0, "(Q-1)+(Q-1)");
                    x = rand_below_q();
                    issue_op(x, x, 1'b1, "u-u");
                    issue_op(24'd0, 24'd1, 1'b1, "0-1");
                end
                idle_cycles(1);
                wait_drain("boundary");
            end
            3: begin
                // back to back, sub mixed at random
                for (i = 0; i < 64; i++) begin
                    r = rand_word();
                    issue_op(rand_below_q(), rand_below_q(), r[0], "stream");
                end
                idle_cycles(1);
                wait_drain("stream");
            end
            4: begin
                for (i = 0; i < 3 && !aborted; i++) begin
                    r = rand_word();
                    issue_op(rand_below_q(), rand_below_q(), r[0], "latency");
                    idle_cycles(1);
                    wait_drain("latency");
                end
            end
            default: begin
                for (i = 0; i < 5; i++) begin
                    issue_op(rand_below_q(), rand_below_q(), 1'b0, "zeroize");
                end
                idle_cycles(10);
                @(posedge clk);
                zeroize <= 1'b1;
                @(posedge clk);
                zeroize <= 1'b0;
                // clear has taken effect at this edge
                for (i = 0; i < LATENCY + 4; i++) begin
                    @(negedge clk);
                    if (valid_out || res0 != 24'd0 || res1 != 24'd0) begin
                        other_err_cnt++;
                        $display("ERROR: output not quiet %0d cycles after zeroize", i);
                    end
                end
                // flushed operations never complete
                exp_q.delete();
                name_q.delete();
                issue_q.delete();
                issue_op(rand_below_q(), rand_below_q(), 1'b1, "after zeroize");
                idle_cycles(1);
                wait_drain("after zeroize");
            end
        endcase
    endtask

    task automatic finish_run();
        int total;
        total = mismatch_cnt + latency_err_cnt + other_err_cnt;
        $display("errors: %0d value mismatches, %0d latency mismatches, %0d other",
                 mismatch_cnt, latency_err_cnt, other_err_cnt);
        if (total == 0 && !aborted) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    //=================================================
    // compare process, outputs sampled mid-cycle
    //=================================================
    always @(negedge clk) begin
        if (reset_n && valid_out) begin
            if (exp_q.size() == 0) begin
                other_err_cnt++;
                $display("ERROR: valid_out went high with no operation outstanding");
            end else begin
                got_val   = res0 + res1;
                exp_val   = exp_q.pop_front();
                exp_name  = name_q.pop_front();
                issued_at = issue_q.pop_front();
                if (got_val != exp_val) begin
                    mismatch_cnt++;
                    $display("MISMATCH %s: expected %0d, actual %0d",
                             exp_name, exp_val, got_val);
                end
                if (cycle_cnt - issued_at != LATENCY) begin
                    latency_err_cnt++;
                    $display("MISMATCH %s latency: expected %0d, actual %0d",
                             exp_name, LATENCY, cycle_cnt - issued_at);
                end
            end
        end
    end

    initial begin
        reset_n  = 1'b0;
        zeroize  = 1'b0;
        valid_in = 1'b0;
        sub      = 1'b0;
        u0       = '0;
        u1       = '0;
        v0       = '0;
        v1       = '0;
        rnd_a2b  = '0;
        rnd_b2a  = '0;
        repeat (10) @(posedge clk);
        reset_n <= 1'b1;
        for (int phase = 0; phase < 6 && !aborted; phase++) begin
            run_phase(phase);
        end
        finish_run();
    end

endmodule

// File: tb.f
+incdir+design
design/masked_arith_pkg.sv
design/masked_share_if.sv
design/operand_prep.sv
design/masked_share_adder.sv
design/a2b_msb_extract.sv
design/b2a_bit_conv.sv
design/share_delay.sv
design/modq_reduce_out.sv
design/masked_addsub_top.sv
sim/tb_masked_addsub.sv

// File: run_sim.sh
#!/bin/sh
# build and run the masked add/sub testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module tb_masked_addsub -f tb.f -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi
exit 1
